// File: design/rvp_pkg.sv
// rv64i pipeline shared types
`default_nettype none

package rvp_pkg;

    parameter int XLEN       = 64;  // integer register width
    parameter int REG_ADDR_W = 5;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,  // signed compare
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8   // lui and link values
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       src1;        // already forwarded
        logic [XLEN-1:0]       src2;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  is_load;
        logic                  is_store;
        logic                  is_ebreak;
        logic                  is_illegal;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  is_load;
        logic                  is_store;
        logic                  is_ebreak;
        logic                  is_illegal;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;      // alu result or load data
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  is_ebreak;
        logic                  is_illegal;
    } mem_wb_t;

    // one retired instruction
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       data;
    } commit_t;

endpackage

`default_nettype wire

// File: design/pipe_reg.sv
// typed pipeline register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = rvp_pkg::if_id_t
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic stall_i,
    input  wire logic flush_i,
    input  wire payload_t d_i,
    output payload_t  q_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_o.valid <= 1'b0;  // payload bits keep whatever they hold
        end else if (flush_i) begin
            q_o <= '0;          // bubble
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: design/if_stage.sv
// instruction fetch
`timescale 1ns/1ps
`default_nettype none

module if_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          stall_i,
    input  wire logic                          redirect_i,
    input  wire logic [rvp_pkg::XLEN-1:0]      redirect_pc_i,
    input  wire logic                          imem_we_i,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  wire logic [31:0]                   imem_data_i,
    output rvp_pkg::if_id_t                    if_o
);
    import rvp_pkg::*;

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0]  pc_q;
    logic [31:0]      imem [IMEM_DEPTH];
    logic [IDX_W-1:0] fetch_idx;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;          // taken branch or jump
        end else if (!stall_i) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    // program load port
    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    assign fetch_idx = pc_q[IDX_W+1:2];   // word addressed

    assign if_o = '{valid: 1'b1, pc: pc_q, inst: imem[fetch_idx]};

    pc_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch pc not word aligned");

endmodule

`default_nettype wire

// File: design/id_stage.sv
// decode, forwarding and hazard control
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire rvp_pkg::if_id_t               id_i,
    input  wire logic [rvp_pkg::XLEN-1:0]      rs1_data_i,
    input  wire logic [rvp_pkg::XLEN-1:0]      rs2_data_i,
    output logic [rvp_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [rvp_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    input  wire rvp_pkg::id_ex_t               ex_fwd_i,
    input  wire logic [rvp_pkg::XLEN-1:0]      ex_res_i,
    input  wire rvp_pkg::mem_wb_t              mem_fwd_i,
    output rvp_pkg::id_ex_t                    id_o,
    output logic                               stall_o,
    output logic                               flush_if_o,
    output logic                               redirect_o,
    output logic [rvp_pkg::XLEN-1:0]           redirect_pc_o
);
    import rvp_pkg::*;

    logic [31:0]           inst;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm_i;
    logic [XLEN-1:0]       imm_s;
    logic [XLEN-1:0]       imm_b;
    logic [XLEN-1:0]       imm_u;
    logic [XLEN-1:0]       imm_j;
    logic [XLEN-1:0]       link_pc;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic                  uses_rs1;
    logic                  uses_rs2;
    logic                  take;
    logic                  load_use;
    logic                  go;
    logic                  halt_q;
    id_ex_t                dec;

    assign inst    = id_i.inst;
    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign imm_i   = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s   = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b   = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u   = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j   = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign link_pc = id_i.pc + XLEN'(4);

    // youngest producer wins, x0 never forwards
    function automatic logic [XLEN-1:0] operand(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0]       rf_val);
        if (addr != '0 && ex_fwd_i.valid && ex_fwd_i.reg_wen && !ex_fwd_i.is_load
            && ex_fwd_i.rd == addr)
            return ex_res_i;
        if (addr != '0 && mem_fwd_i.valid && mem_fwd_i.reg_wen && mem_fwd_i.rd == addr)
            return mem_fwd_i.result;
        return rf_val;
    endfunction

    always_comb begin
        op_a = operand(rs1, rs1_data_i);
        op_b = operand(rs2, rs2_data_i);
    end

    always_comb begin
        dec            = '0;
        dec.pc         = id_i.pc;
        dec.rd         = inst[11:7];
        dec.alu_op     = ALU_ADD;
        dec.src1       = op_a;
        dec.src2       = imm_i;
        dec.store_data = op_b;
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b0;
        take           = 1'b0;
        redirect_pc_o  = id_i.pc + imm_b;
        case (opcode)
            OPC_OP_IMM: begin
                dec.reg_wen = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b101:  begin
                        dec.alu_op     = ALU_SRL;
                        dec.is_illegal = inst[30];  // srai
                    end
                    default: dec.is_illegal = 1'b1;
                endcase
            end
            OPC_OP: begin
                dec.reg_wen = 1'b1;
                dec.src2    = op_b;
                uses_rs2    = 1'b1;
                case ({inst[30], funct3})
                    4'b0_000: dec.alu_op = ALU_ADD;
                    4'b1_000: dec.alu_op = ALU_SUB;
                    4'b0_111: dec.alu_op = ALU_AND;
                    4'b0_110: dec.alu_op = ALU_OR;
                    4'b0_100: dec.alu_op = ALU_XOR;
                    4'b0_010: dec.alu_op = ALU_SLT;
                    default:  dec.is_illegal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                uses_rs1    = 1'b0;
                dec.reg_wen = 1'b1;
                dec.alu_op  = ALU_PASS_B;
                dec.src2    = imm_u;
            end
            OPC_LOAD: begin
                dec.reg_wen    = 1'b1;
                dec.is_load    = 1'b1;
                dec.is_illegal = funct3 != 3'b011;  // ld only
            end
            OPC_STORE: begin
                uses_rs2       = 1'b1;
                dec.src2       = imm_s;
                dec.is_store   = funct3 == 3'b011;
                dec.is_illegal = funct3 != 3'b011;
            end
            OPC_BRANCH: begin
                uses_rs2 = 1'b1;
                case (funct3)
                    3'b000:  take = op_a == op_b;
                    3'b001:  take = op_a != op_b;
                    default: dec.is_illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                uses_rs1      = 1'b0;
                take          = 1'b1;
                redirect_pc_o = id_i.pc + imm_j;
                dec.reg_wen   = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.src2      = link_pc;
            end
            OPC_JALR: begin
                take          = 1'b1;
                redirect_pc_o = (op_a + imm_i) & ~XLEN'(1);
                dec.reg_wen   = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.src2      = link_pc;
            end
            OPC_SYSTEM: begin
                uses_rs1       = 1'b0;
                dec.is_ebreak  = inst[31:7] == 25'h0002000;
                dec.is_illegal = inst[31:7] != 25'h0002000;
            end
            default: begin
                uses_rs1       = 1'b0;
                dec.is_illegal = 1'b1;
            end
        endcase
        if (dec.is_illegal) begin
            dec.reg_wen = 1'b0;
        end
    end

    // load in ex feeding this instruction
    assign load_use = id_i.valid && ex_fwd_i.valid && ex_fwd_i.is_load && ex_fwd_i.rd != '0
                      && ((uses_rs1 && ex_fwd_i.rd == rs1) || (uses_rs2 && ex_fwd_i.rd == rs2));

    assign stall_o    = halt_q || load_use;
    assign go         = id_i.valid && !stall_o;
    assign redirect_o = go && take;
    assign flush_if_o = redirect_o;   // drop the wrong-path fetch
    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    always_comb begin
        id_o       = dec;
        id_o.valid = go;    // bubble while stalled
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halt_q <= 1'b0;
        end else if (go && (dec.is_ebreak || dec.is_illegal)) begin
            halt_q <= 1'b1;  // sticky until reset
        end
    end

    // the bubble behind a load clears the hazard next cycle
    load_use_one_cycle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_use |=> !load_use)
        else $error("load-use stall held for more than one cycle");

endmodule

`default_nettype wire

// File: design/ex_stage.sv
// execute stage alu
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire rvp_pkg::id_ex_t          ex_i,
    output logic [rvp_pkg::XLEN-1:0]      res_o,
    output rvp_pkg::ex_mem_t              mem_o
);
    import rvp_pkg::*;

    logic [5:0] shamt;

    assign shamt = ex_i.src2[5:0];  // rv64 shift range

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    res_o = ex_i.src1 + ex_i.src2;
            ALU_SUB:    res_o = ex_i.src1 - ex_i.src2;
            ALU_AND:    res_o = ex_i.src1 & ex_i.src2;
            ALU_OR:     res_o = ex_i.src1 | ex_i.src2;
            ALU_XOR:    res_o = ex_i.src1 ^ ex_i.src2;
            ALU_SLT:    res_o = XLEN'($signed(ex_i.src1) < $signed(ex_i.src2));
            ALU_SLL:    res_o = ex_i.src1 << shamt;
            ALU_SRL:    res_o = ex_i.src1 >> shamt;
            ALU_PASS_B: res_o = ex_i.src2;
            default:    res_o = '0;
        endcase
    end

    assign mem_o = '{
        valid:      ex_i.valid,
        pc:         ex_i.pc,
        alu_res:    res_o,
        store_data: ex_i.store_data,
        rd:         ex_i.rd,
        reg_wen:    ex_i.reg_wen,
        is_load:    ex_i.is_load,
        is_store:   ex_i.is_store,
        is_ebreak:  ex_i.is_ebreak,
        is_illegal: ex_i.is_illegal
    };

endmodule

`default_nettype wire

// File: design/mem_stage.sv
// data memory stage
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int DMEM_DEPTH = 128
) (
    input  wire logic              clk_i,
    input  wire rvp_pkg::ex_mem_t  mem_i,
    output rvp_pkg::mem_wb_t       wb_o
);
    import rvp_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]  dmem [DMEM_DEPTH];
    logic [IDX_W-1:0] idx;

    assign idx = mem_i.alu_res[IDX_W+2:3];  // doubleword index

    always_ff @(posedge clk_i) begin
        if (mem_i.valid && mem_i.is_store) begin
            dmem[idx] <= mem_i.store_data;
        end
    end

    assign wb_o = '{
        valid:      mem_i.valid,
        pc:         mem_i.pc,
        result:     mem_i.is_load ? dmem[idx] : mem_i.alu_res,
        rd:         mem_i.rd,
        reg_wen:    mem_i.reg_wen,
        is_ebreak:  mem_i.is_ebreak,
        is_illegal: mem_i.is_illegal
    };

    dw_aligned_a: assert property (@(posedge clk_i)
        (mem_i.valid && (mem_i.is_load || mem_i.is_store)) |-> mem_i.alu_res[2:0] == 3'b000)
        else $error("misaligned doubleword access");

endmodule

`default_nettype wire

// File: design/wb_stage.sv
// writeback and register file
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire rvp_pkg::mem_wb_t              wb_i,
    input  wire logic [rvp_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  wire logic [rvp_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rvp_pkg::XLEN-1:0]           rs1_data_o,
    output logic [rvp_pkg::XLEN-1:0]           rs2_data_o,
    output logic                               commit_valid_o,
    output rvp_pkg::commit_t                   commit_o,
    output logic                               halted_o,
    output logic                               illegal_o
);
    import rvp_pkg::*;

    logic [XLEN-1:0] rf [1:31];  // x0 not stored
    logic            wr_en;

    assign wr_en = wb_i.valid && wb_i.reg_wen && wb_i.rd != '0;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            rf[wb_i.rd] <= wb_i.result;
        end
    end

    // write-first read
    function automatic logic [XLEN-1:0] rf_read(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wr_en && wb_i.rd == addr)
            return wb_i.result;
        return rf[addr];
    endfunction

    always_comb begin
        rs1_data_o = rf_read(rs1_addr_i);
        rs2_data_o = rf_read(rs2_addr_i);
    end

    assign commit_valid_o = wb_i.valid;
    assign commit_o       = '{pc: wb_i.pc, rd: wb_i.rd, wen: wr_en, data: wb_i.result};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            halted_o  <= 1'b0;
            illegal_o <= 1'b0;
        end else if (wb_i.valid && (wb_i.is_ebreak || wb_i.is_illegal)) begin
            halted_o  <= 1'b1;
            illegal_o <= wb_i.is_illegal;
        end
    end

endmodule

`default_nettype wire

// File: design/rvp_top.sv
// rv64i five-stage pipeline top
`timescale 1ns/1ps
`default_nettype none

module rvp_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 128
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_n_i,
    input  wire logic                          imem_we_i,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  wire logic [31:0]                   imem_data_i,
    output logic                               commit_valid_o,
    output rvp_pkg::commit_t                   commit_o,
    output logic                               halted_o,
    output logic                               illegal_o
);
    import rvp_pkg::*;

    if_id_t                if_d;
    if_id_t                if_q;
    id_ex_t                id_d;
    id_ex_t                id_q;
    ex_mem_t               ex_d;
    ex_mem_t               ex_q;
    mem_wb_t               mem_d;
    mem_wb_t               mem_q;
    logic [XLEN-1:0]       ex_res;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic                  id_stall;
    logic                  if_flush;
    logic                  redirect;
    logic [XLEN-1:0]       redirect_pc;

    if_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_if_stage (
        .clk_i, .rst_n_i,
        .stall_i       (id_stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_we_i, .imem_addr_i, .imem_data_i,
        .if_o          (if_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk_i, .rst_n_i,
        .stall_i (id_stall),
        .flush_i (if_flush),
        .d_i     (if_d),
        .q_o     (if_q)
    );

    id_stage u_id_stage (
        .clk_i, .rst_n_i,
        .id_i          (if_q),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .ex_fwd_i      (id_q),      // instruction now in ex
        .ex_res_i      (ex_res),
        .mem_fwd_i     (mem_d),     // instruction now in mem
        .id_o          (id_d),
        .stall_o       (id_stall),
        .flush_if_o    (if_flush),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk_i, .rst_n_i,
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (id_d),
        .q_o     (id_q)
    );

    ex_stage u_ex_stage (
        .ex_i  (id_q),
        .res_o (ex_res),
        .mem_o (ex_d)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk_i, .rst_n_i,
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (ex_d),
        .q_o     (ex_q)
    );

    mem_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem_stage (
        .clk_i,
        .mem_i (ex_q),
        .wb_o  (mem_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk_i, .rst_n_i,
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (mem_d),
        .q_o     (mem_q)
    );

    wb_stage u_wb_stage (
        .clk_i, .rst_n_i,
        .wb_i       (mem_q),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .commit_valid_o, .commit_o, .halted_o, .illegal_o
    );

endmodule

`default_nettype wire

// File: tb/rvp_tb.sv
// rv64i pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module rvp_tb;
    import rvp_pkg::*;

    logic             clk;
    logic             rst_n;
    logic             imem_we;
    logic [7:0]       imem_addr;
    logic [31:0]      imem_data;
    logic             commit_valid;
    commit_t          commit;
    logic             halted;
    logic             illegal;

    logic [31:0]      prog [$];
    commit_t          exp_q [$];
    logic             exp_illegal;
    logic [15:0]      lfsr_q = 16'd25858;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_bad = 0;
    logic             running = 1'b0;
    int               budget = 0;
    int               watch_cyc = 0;

    rvp_top #(.IMEM_DEPTH(256), .DMEM_DEPTH(128)) dut0 (
        .clk_i (clk), .rst_n_i (rst_n),
        .imem_we_i (imem_we), .imem_addr_i (imem_addr), .imem_data_i (imem_data),
        .commit_valid_o (commit_valid), .commit_o (commit),
        .halted_o (halted), .illegal_o (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // galois lfsr, one step per bit
    function automatic int lfsr_take(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr_q[0];
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // instruction-set model, fills exp_q
    function automatic void run_model();
        logic [63:0] x [32];
        logic [63:0] dm [128];
        logic [63:0] pc;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm;
        logic [63:0] res;
        logic [63:0] next_pc;
        logic [31:0] w;
        logic        wen;
        commit_t     c;
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = '0;
        exp_illegal = 1'b0;
        for (int step = 0; step < 2000; step++) begin
            w = prog[pc >> 2];
            a = x[w[19:15]];
            b = x[w[24:20]];
            imm = 64'($signed(w[31:20]));
            res = '0;
            wen = 1'b1;
            next_pc = pc + 4;
            case (w[6:0])
                7'h13: case (w[14:12])
                    3'd0: res = a + imm;
                    3'd2: res = ($signed(a) < $signed(imm)) ? 64'd1 : 64'd0;
                    3'd4: res = a ^ imm;
                    3'd6: res = a | imm;
                    3'd7: res = a & imm;
                    3'd1: res = a << imm[5:0];
                    default: res = a >> imm[5:0];
                endcase
                7'h33: case ({w[30], w[14:12]})
                    4'b1000: res = a - b;
                    4'b0111: res = a & b;
                    4'b0110: res = a | b;
                    4'b0100: res = a ^ b;
                    4'b0010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                    default: res = a + b;
                endcase
                7'h37: res = {{32{w[31]}}, w[31:12], 12'h000};
                7'h03: res = dm[((a + imm) >> 3) & 127];
                7'h23: begin
                    wen = 1'b0;
                    dm[((a + 64'($signed({w[31:25], w[11:7]}))) >> 3) & 127] = b;
                end
                7'h63: begin
                    wen = 1'b0;
                    if ((w[12] == 1'b0) == (a == b))
                        next_pc = pc + 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                end
                7'h6f: begin
                    res = pc + 4;
                    next_pc = pc + 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                end
                7'h67: begin
                    res = pc + 4;
                    next_pc = (a + imm) & ~64'd1;
                end
                default: begin
                    wen = 1'b0;
                    exp_illegal = (w != 32'h00100073);
                end
            endcase
            if (w[11:7] == 5'd0) wen = 1'b0;
            if (wen) x[w[11:7]] = res;
            c.pc = pc;
            c.rd = w[11:7];
            c.wen = wen;
            c.data = res;
            exp_q.push_back(c);
            if (w[6:0] == 7'h73 || !(w[6:0] inside {7'h13, 7'h33, 7'h37, 7'h03, 7'h23,
                                                    7'h63, 7'h6f, 7'h67}))
                break;  // ebreak or unknown opcode stops the model
            pc = next_pc;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // commit compare
    initial begin
        commit_t e;
        forever begin
            @(negedge clk);
            if (running && rst_n && commit_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("t=%0t commit at pc %h after the expected stream ended",
                             $time, commit.pc);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("commit.pc", commit.pc, e.pc);
                    check_value("commit.wen", commit.wen, e.wen);
                    if (e.wen) begin
                        check_value("commit.rd", commit.rd, e.rd);
                        check_value("commit.data", commit.data, e.data);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        watch_cyc <= running ? watch_cyc + 1 : 0;
    end

    initial begin
        while (!(running && watch_cyc > budget)) @(posedge clk);
        $display("timeout after %0d cycles, core never halted", watch_cyc);
        $display("Simulation failed");
        $finish;
    end

    task automatic run_program(input string name);
        int errs_before;
        errs_before = errors;
        exp_q.delete();
        run_model();
        @(negedge clk);
        running = 1'b0;
        rst_n = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            imem_we = 1'b1;
            imem_addr = 8'(i);
            imem_data = prog[i];
            @(negedge clk);
        end
        imem_we = 1'b0;
        repeat (5) @(negedge clk);
        budget = 20 * prog.size() + 50;
        rst_n = 1'b1;
        running = 1'b1;
        while (halted !== 1'b1) @(negedge clk);
        repeat (4) @(negedge clk);  // catch stray commits
        @(posedge clk);             // last compare is done by now
        check_value("illegal_o", illegal, exp_illegal);
        if (exp_q.size() != 0) begin
            $display("t=%0t %0d expected commits never appeared", $time, exp_q.size());
            errors++;
        end
        running = 1'b0;
        tests_run++;
        if (errors != errs_before) tests_bad++;
        $display("test %-10s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "FAIL", errors - errs_before);
    endtask

    initial begin
        int sel;
        int rd;
        rst_n = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;

        // random straight-line alu
        prog.delete();
        for (int r = 1; r <= 8; r++) begin
            prog.push_back({20'(lfsr_take(20)), 5'(r), 7'h37});
            prog.push_back(enc_i(7'h13, 3'd0, r, r, lfsr_take(12)));
        end
        for (int k = 0; k < 40; k++) begin
            sel = k % 14;  // every alu op in turn
            rd = lfsr_take(3) + 1;
            case (sel)
                0, 1, 2, 3, 4: prog.push_back(enc_i(7'h13, (sel == 0) ? 3'd0 : (sel == 1) ? 3'd2 :
                    (sel == 2) ? 3'd7 : (sel == 3) ? 3'd6 : 3'd4, rd, lfsr_take(4) % 9,
                    lfsr_take(12)));
                5: prog.push_back(enc_i(7'h13, 3'd1, rd, lfsr_take(4) % 9, lfsr_take(6)));
                6: prog.push_back(enc_i(7'h13, 3'd5, rd, lfsr_take(4) % 9, lfsr_take(6)));
                7, 8, 9, 10, 11, 12: prog.push_back(enc_r((sel == 8) ? 7'h20 : 7'h00,
                    (sel <= 8) ? 3'd0 : (sel == 9) ? 3'd7 : (sel == 10) ? 3'd6 :
                    (sel == 11) ? 3'd4 : 3'd2, rd, lfsr_take(4) % 9, lfsr_take(4) % 9));
                default: prog.push_back({20'(lfsr_take(20)), 5'(rd), 7'h37});
            endcase
        end
        prog.push_back(32'h00100073);
        run_program("alu_rand");

        // forwarding from ex, mem and the register file
        prog = '{enc_i(7'h13, 3'd0, 1, 0, 5), enc_r(7'h00, 3'd0, 2, 1, 1),
                 enc_r(7'h00, 3'd0, 3, 1, 2), enc_r(7'h20, 3'd0, 4, 3, 1),
                 enc_r(7'h00, 3'd4, 5, 2, 4), enc_i(7'h13, 3'd1, 6, 5, 33),
                 enc_r(7'h00, 3'd2, 7, 4, 6), 32'h00100073};
        run_program("forward");

        // store, load and load-use stall
        prog = '{enc_i(7'h13, 3'd0, 5, 0, 64), enc_i(7'h13, 3'd0, 1, 0, -77),
                 enc_s(1, 5, 0), enc_i(7'h03, 3'd3, 2, 5, 0), enc_r(7'h00, 3'd0, 3, 2, 2),
                 enc_s(3, 5, 8), enc_i(7'h03, 3'd3, 4, 5, 8), enc_i(7'h13, 3'd0, 6, 4, 1),
                 enc_r(7'h00, 3'd0, 7, 6, 4), 32'h00100073};
        run_program("load_store");

        // loop, branches and jumps
        prog = '{enc_i(7'h13, 3'd0, 1, 0, 5), enc_i(7'h13, 3'd0, 2, 0, 0),
                 enc_i(7'h13, 3'd0, 2, 2, 3), enc_i(7'h13, 3'd0, 1, 1, -1),
                 enc_b(3'd1, 1, 0, -8), enc_b(3'd0, 0, 0, 8), enc_i(7'h13, 3'd0, 7, 0, 99),
                 enc_b(3'd0, 1, 2, 8), enc_j(3, 12), enc_i(7'h13, 3'd0, 8, 0, 1),
                 enc_i(7'h13, 3'd0, 9, 0, 1), enc_i(7'h13, 3'd0, 10, 0, 64),
                 enc_i(7'h67, 3'd0, 11, 10, 0), enc_i(7'h13, 3'd0, 12, 0, 1),
                 enc_i(7'h13, 3'd0, 12, 0, 2), enc_i(7'h13, 3'd0, 12, 0, 3),
                 enc_r(7'h00, 3'd0, 13, 3, 11), 32'h00100073};
        run_program("branch");

        prog = '{enc_i(7'h13, 3'd0, 1, 0, 1), 32'h00100073, enc_i(7'h13, 3'd0, 2, 0, 2),
                 enc_i(7'h13, 3'd0, 3, 0, 3)};
        run_program("ebreak");

        // opcode 7f is not decoded
        prog = '{enc_i(7'h13, 3'd0, 1, 0, 7), 32'h0000007f, enc_i(7'h13, 3'd0, 2, 0, 2),
                 32'h00100073};
        run_program("illegal");

        $display("%0d tests, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/rvp_pkg.sv
design/pipe_reg.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/rvp_top.sv
tb/rvp_tb.sv

// File: Bender.yml
package:
  name: rvp

sources:
  - design/rvp_pkg.sv
  - design/pipe_reg.sv
  - design/if_stage.sv
  - design/id_stage.sv
  - design/ex_stage.sv
  - design/mem_stage.sv
  - design/wb_stage.sv
  - design/rvp_top.sv
  - target: test
    files:
      - tb/rvp_tb.sv
